// ==== logic/port_a_pkg.sv ====
package port_a_pkg;

    // ------------------------------
    // Port line types
    // ------------------------------
    // Bit 5..0 = pin 7, pin 6, right, left, down, up; active low
    typedef logic [5:0] joy_lines_t;

    localparam joy_lines_t JOY_IDLE = 6'b111111;  // Nothing pressed, nothing driven
    localparam int JOY_PIN6 = 4;                  // Trigger A, used as VAUS shift clock

    // One PS/2 mouse delta, two's complement
    typedef logic signed [7:0] mouse_delta_t;

    // ------------------------------
    // Paddle emulation
    // ------------------------------
    typedef logic [1:0] pad_mode_t;

    localparam pad_mode_t PAD_NONE = 2'd0;
    localparam pad_mode_t PAD_VAUS = 2'd1;
    localparam pad_mode_t PAD_MSX  = 2'd2;

    typedef logic [8:0] paddle_pos_t;

    // Arkanoid VAUS knob range
    localparam paddle_pos_t VAUS_MIN    = 9'd110;
    localparam paddle_pos_t VAUS_MAX    = 9'd380;
    localparam paddle_pos_t VAUS_CENTER = 9'd236;

    // Time encoded MSX paddle, lower limit is zero
    localparam paddle_pos_t MSXPAD_MAX    = 9'd275;
    localparam paddle_pos_t MSXPAD_CENTER = 9'd127;

    // Codes 1 and 3 both select VAUS
    function automatic logic pad_is_vaus(input pad_mode_t mode);
        return mode[0];
    endfunction

    function automatic logic pad_is_msx(input pad_mode_t mode);
        return mode == PAD_MSX;
    endfunction

endpackage

// ==== logic/port_a_connect.sv ====
`timescale 1ns/100ps

module port_a_connect import port_a_pkg::*; #(
    parameter int DISC_TICKS    = 800000,
    parameter int PRESCALE_BITS = 5
) (
    input  logic       clk_sys,
    input  logic       reset,
    input  joy_lines_t joy_i,
    input  pad_mode_t  pad_mode_i,
    input  logic [1:0] mouse_btn_i,
    input  logic       mouse_present_i,
    input  joy_lines_t mouse_lines_i,
    input  logic       pad_data_i,
    output logic       port_en_o,
    output joy_lines_t joy_o
);

    localparam int CNT_W = (DISC_TICKS < 1) ? 1 : $clog2(DISC_TICKS + 1);

    logic [PRESCALE_BITS-1:0] prescale_cnt;
    logic [CNT_W-1:0]         disc_cnt;
    pad_mode_t                pad_mode_q;
    logic                     present_q;
    logic                     dev_change;
    logic                     tick;

    // ------------------------------
    // Disconnect window
    // ------------------------------
    // Old device must look unplugged for a while before the new one shows up
    assign dev_change = (pad_mode_i != pad_mode_q) || (mouse_present_i != present_q);
    assign tick       = &prescale_cnt;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            prescale_cnt <= '0;
            pad_mode_q   <= PAD_NONE;
            present_q    <= 1'b0;
            disc_cnt     <= CNT_W'(DISC_TICKS);
            port_en_o    <= 1'b0;
        end else begin
            prescale_cnt <= prescale_cnt + 1'b1;  // Free running
            pad_mode_q   <= pad_mode_i;
            present_q    <= mouse_present_i;

            if (dev_change) begin
                disc_cnt  <= CNT_W'(DISC_TICKS);
                port_en_o <= 1'b0;
            end else if (tick) begin
                if (disc_cnt != '0)
                    disc_cnt <= disc_cnt - 1'b1;
                else
                    port_en_o <= 1'b1;  // Window over, plug back in
            end
        end
    end

    // ------------------------------
    // Line source select
    // ------------------------------
    always_comb begin
        if (!port_en_o)
            joy_o = JOY_IDLE;
        else if (pad_is_vaus(pad_mode_i))
            joy_o = {2'b11, pad_data_i, mouse_btn_i[1] & mouse_btn_i[0], 2'b11};
        else if (pad_is_msx(pad_mode_i))
            joy_o = {mouse_btn_i[1:0], pad_data_i, 3'b111};  // Buttons on pins 7 and 6
        else if (mouse_present_i)
            joy_o = mouse_lines_i;
        else
            joy_o = joy_i;  // Plain joystick
    end

endmodule

// ==== logic/mouse_serializer.sv ====
`timescale 1ns/100ps

module mouse_serializer import port_a_pkg::*; #(
    parameter int MOUSE_TIMEOUT = 50000
) (
    input  logic         clk_sys,
    input  logic         reset,
    input  joy_lines_t   joy_i,
    input  logic         stra_i,
    input  logic         mouse_strobe_i,
    input  mouse_delta_t mouse_x_i,
    input  mouse_delta_t mouse_y_i,
    input  logic [1:0]   mouse_btn_i,
    output logic         mouse_present_o,
    output joy_lines_t   mouse_lines_o
);

    localparam int TO_W = (MOUSE_TIMEOUT < 1) ? 1 : $clog2(MOUSE_TIMEOUT + 1);

    logic              strobe_q;
    logic              stra_q;
    logic              stra_qq;
    logic              stra_toggle;
    logic              strobe_rise;
    logic [1:0]        phase;
    logic [TO_W-1:0]   timeout_cnt;
    mouse_delta_t      x_latch;
    mouse_delta_t      y_latch;

    // MSX reads the nibble with the top bit on up and the bottom bit on right
    function automatic logic [3:0] swap_nibble(input logic [3:0] n);
        return {n[0], n[1], n[2], n[3]};
    endfunction

    assign strobe_rise = mouse_strobe_i && !strobe_q;
    assign stra_toggle = stra_q != stra_qq;

    // ------------------------------
    // Delta latches
    // ------------------------------
    always_ff @(posedge clk_sys) begin
        if (mouse_present_o && stra_toggle && phase == 2'd3) begin
            x_latch <= '0;  // Deltas consumed
            y_latch <= '0;
        end
        if (strobe_rise) begin
            x_latch <= mouse_x_i;
            y_latch <= mouse_y_i;
        end
    end

    // ------------------------------
    // Presence and nibble stepping
    // ------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            strobe_q        <= 1'b0;
            stra_q          <= 1'b0;
            stra_qq         <= 1'b0;
            mouse_present_o <= 1'b0;
            phase           <= 2'd0;
            timeout_cnt     <= TO_W'(MOUSE_TIMEOUT);
            mouse_lines_o   <= JOY_IDLE;
        end else begin
            strobe_q <= mouse_strobe_i;
            stra_q   <= stra_i;
            stra_qq  <= stra_q;
            mouse_lines_o[5:4] <= mouse_btn_i;  // Pin 7 right, pin 6 left

            if (mouse_strobe_i)
                mouse_present_o <= 1'b1;
            else if (joy_i != JOY_IDLE)
                mouse_present_o <= 1'b0;  // Real joystick took over

            if (mouse_present_o) begin
                if (stra_toggle) begin
                    timeout_cnt <= TO_W'(MOUSE_TIMEOUT);
                    phase       <= phase + 1'b1;
                    case (phase)
                        2'd0: mouse_lines_o[3:0] <= swap_nibble(x_latch[7:4]);
                        2'd1: mouse_lines_o[3:0] <= swap_nibble(x_latch[3:0]);
                        2'd2: mouse_lines_o[3:0] <= swap_nibble(y_latch[7:4]);
                        default: mouse_lines_o[3:0] <= swap_nibble(y_latch[3:0]);
                    endcase
                end else if (timeout_cnt != '0) begin
                    timeout_cnt <= timeout_cnt - 1'b1;
                    if (timeout_cnt == TO_W'(1))
                        phase <= 2'd0;  // Host gave up, restart at X high
                end
            end
        end
    end

endmodule

// ==== logic/paddle_position.sv ====
`timescale 1ns/100ps

module paddle_position import port_a_pkg::*; (
    input  logic         clk_sys,
    input  logic         reset,
    input  logic         mouse_strobe_i,
    input  mouse_delta_t mouse_x_i,
    input  logic         recenter_i,
    output paddle_pos_t  vaus_pos_o,
    output paddle_pos_t  msx_pos_o
);

    logic        strobe_q;
    logic        move;
    paddle_pos_t mag;
    paddle_pos_t vaus_next;
    paddle_pos_t msx_next;

    assign move = mouse_strobe_i && !strobe_q && (mouse_x_i != '0);

    // Positive X moves the knob left, negative moves it right
    always_comb begin
        if (!mouse_x_i[7]) begin
            mag = {2'b00, mouse_x_i[6:0]};

            if (vaus_pos_o < mag)
                vaus_next = VAUS_MIN;  // Would wrap
            else
                vaus_next = vaus_pos_o - mag;
            if (vaus_next < VAUS_MIN)
                vaus_next = VAUS_MIN;

            if (msx_pos_o < mag)
                msx_next = '0;
            else
                msx_next = msx_pos_o - mag;
        end else begin
            mag = {2'b00, ~mouse_x_i[6:0]} + 9'd1;  // Magnitude, up to 128

            vaus_next = vaus_pos_o + mag;
            if (vaus_next > VAUS_MAX)
                vaus_next = VAUS_MAX;

            msx_next = msx_pos_o + mag;
            if (msx_next > MSXPAD_MAX)
                msx_next = MSXPAD_MAX;
        end
    end

    // ------------------------------
    // Position registers
    // ------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            strobe_q   <= 1'b0;
            vaus_pos_o <= VAUS_CENTER;
            msx_pos_o  <= MSXPAD_CENTER;
        end else begin
            strobe_q <= mouse_strobe_i;
            if (recenter_i) begin
                vaus_pos_o <= VAUS_CENTER;
                msx_pos_o  <= MSXPAD_CENTER;
            end else if (move) begin
                vaus_pos_o <= vaus_next;
                msx_pos_o  <= msx_next;
            end
        end
    end

endmodule

// ==== logic/paddle_fsm.sv ====
`timescale 1ns/100ps

module paddle_fsm import port_a_pkg::*; #(
    parameter int SCALER_TICKS = 257
) (
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        port_en_i,
    input  pad_mode_t   pad_mode_i,
    input  logic        stra_i,
    input  joy_lines_t  joy_i,
    input  paddle_pos_t vaus_pos_i,
    input  paddle_pos_t msx_pos_i,
    output logic        pad_data_o,
    output logic        recenter_o
);

    localparam int SC_W = (SCALER_TICKS < 1) ? 1 : $clog2(SCALER_TICKS + 1);

    typedef enum logic [1:0] {
        STARTUP,
        WORK,
        COUNT,
        TAIL
    } state_t;

    state_t      state;
    paddle_pos_t shift_reg;
    paddle_pos_t pad_cnt;
    logic [SC_W-1:0] scaler;
    logic        stra_q;
    logic        stra_qq;
    logic        p6_q;
    logic        p6_qq;
    logic        stra_rise;
    logic        p6_rise;

    assign stra_rise  = stra_q && !stra_qq;
    assign p6_rise    = p6_q && !p6_qq;
    assign recenter_o = state == STARTUP;

    // ------------------------------
    // Paddle state machine
    // ------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state      <= STARTUP;
            pad_data_o <= 1'b1;
            shift_reg  <= '0;
            pad_cnt    <= '0;
            scaler     <= '0;
            stra_q     <= 1'b0;
            stra_qq    <= 1'b0;
            p6_q       <= 1'b0;
            p6_qq      <= 1'b0;
        end else begin
            stra_q  <= stra_i;
            stra_qq <= stra_q;
            p6_q    <= joy_i[JOY_PIN6];
            p6_qq   <= p6_q;

            case (state)
                STARTUP: begin
                    pad_data_o <= 1'b1;  // Released
                    shift_reg  <= '0;
                    state      <= WORK;
                end
                WORK: begin
                    if (pad_is_vaus(pad_mode_i)) begin
                        pad_data_o <= shift_reg[8];  // MSB first
                        if (stra_rise)
                            shift_reg <= vaus_pos_i;
                        else if (p6_rise)
                            shift_reg <= {shift_reg[7:0], 1'b0};
                    end else if (pad_is_msx(pad_mode_i)) begin
                        pad_data_o <= 1'b0;
                        if (stra_rise) begin
                            pad_cnt    <= msx_pos_i;
                            scaler     <= SC_W'(SCALER_TICKS);
                            pad_data_o <= 1'b1;  // Start of the timed pulse
                            state      <= COUNT;
                        end
                    end
                end
                COUNT: begin
                    // One scaler period per position step
                    if (pad_cnt != '0) begin
                        if (scaler != '0) begin
                            scaler <= scaler - 1'b1;
                        end else begin
                            scaler  <= SC_W'(SCALER_TICKS);
                            pad_cnt <= pad_cnt - 1'b1;
                        end
                    end else begin
                        scaler <= SC_W'(SCALER_TICKS);
                        state  <= TAIL;
                    end
                end
                default: begin
                    // Extra period so position 0 still gives a pulse
                    if (scaler != '0)
                        scaler <= scaler - 1'b1;
                    else
                        state <= WORK;
                end
            endcase

            if (!port_en_i)
                state <= STARTUP;  // Hold while disconnected
        end
    end

endmodule

// ==== logic/port_a_top.sv ====
`timescale 1ns/100ps

module port_a_top import port_a_pkg::*; #(
    parameter int DISC_TICKS    = 800000,  // About 1 s at 21.48 MHz
    parameter int PRESCALE_BITS = 5,
    parameter int MOUSE_TIMEOUT = 50000,
    parameter int SCALER_TICKS  = 257      // About 12 us per paddle step
) (
    input  logic         clk_sys,
    input  logic         reset,
    input  joy_lines_t   joy_i,
    input  pad_mode_t    pad_mode_i,
    input  logic         stra_i,
    input  logic         mouse_strobe_i,
    input  mouse_delta_t mouse_x_i,
    input  mouse_delta_t mouse_y_i,
    input  logic [1:0]   mouse_btn_i,
    output joy_lines_t   joy_o
);

    joy_lines_t  mouse_lines;
    logic        mouse_present;
    paddle_pos_t vaus_pos;
    paddle_pos_t msx_pos;
    logic        pad_data;
    logic        recenter;
    logic        port_en;

    port_a_connect #(
        .DISC_TICKS    (DISC_TICKS),
        .PRESCALE_BITS (PRESCALE_BITS)
    ) u_connect (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .joy_i           (joy_i),
        .pad_mode_i      (pad_mode_i),
        .mouse_btn_i     (mouse_btn_i),
        .mouse_present_i (mouse_present),
        .mouse_lines_i   (mouse_lines),
        .pad_data_i      (pad_data),
        .port_en_o       (port_en),
        .joy_o           (joy_o)
    );

    mouse_serializer #(
        .MOUSE_TIMEOUT (MOUSE_TIMEOUT)
    ) u_mouse (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .joy_i           (joy_i),
        .stra_i          (stra_i),
        .mouse_strobe_i  (mouse_strobe_i),
        .mouse_x_i       (mouse_x_i),
        .mouse_y_i       (mouse_y_i),
        .mouse_btn_i     (mouse_btn_i),
        .mouse_present_o (mouse_present),
        .mouse_lines_o   (mouse_lines)
    );

    paddle_position u_pad_pos (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .mouse_strobe_i (mouse_strobe_i),
        .mouse_x_i      (mouse_x_i),
        .recenter_i     (recenter),
        .vaus_pos_o     (vaus_pos),
        .msx_pos_o      (msx_pos)
    );

    paddle_fsm #(
        .SCALER_TICKS (SCALER_TICKS)
    ) u_pad_fsm (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .port_en_i  (port_en),
        .pad_mode_i (pad_mode_i),
        .stra_i     (stra_i),
        .joy_i      (joy_i),
        .vaus_pos_i (vaus_pos),
        .msx_pos_i  (msx_pos),
        .pad_data_o (pad_data),
        .recenter_o (recenter)
    );

endmodule

// ==== dv/port_a_tests.svh ====
// MSX mouse nibble as it shows on up, down, left, right
function automatic logic [3:0] reverse_nibble(input logic [3:0] n);
    logic [3:0] r;
    for (int i = 0; i < 4; i++)
        r[i] = n[3 - i];
    return r;
endfunction

task automatic reset_and_passthrough();
    lcg_state = lcg_next(lcg_state);
    joy_i     = lcg_state[5:0] & 6'b011111;  // Pin 7 pressed
    wait_cycles(1);
    check_value(32'(joy_o), 32'(JOY_IDLE), "Port released after reset");
    wait_cycles(WAIT_BOUND);
    repeat (6) begin
        lcg_state = lcg_next(lcg_state);
        joy_i     = lcg_state[21:16];
        wait_cycles(1);
        check_value(32'(joy_o), 32'(joy_i), "Joystick pass-through");
    end
    joy_i = JOY_IDLE;
    wait_cycles(1);
endtask

task automatic mouse_nibbles();
    logic [3:0]   nibs [5];
    mouse_delta_t mx;
    mouse_delta_t my;
    lcg_state   = lcg_next(lcg_state);
    mx          = lcg_state[15:8];
    my          = lcg_state[23:16];
    mouse_btn_i = lcg_state[25:24];
    nibs        = '{mx[7:4], mx[3:0], my[7:4], my[3:0], 4'h0};  // Last read after latch clear
    send_mouse(mx, my);
    wait_cycles(WAIT_BOUND);  // Presence change disconnects the port
    for (int i = 0; i < 5; i++) begin
        stra_i = ~stra_i;
        wait_cycles(3);
        check_value(32'(joy_o), 32'({mouse_btn_i, reverse_nibble(nibs[i])}),
                    $sformatf("Mouse nibble %0d", i));
    end
endtask

task automatic mouse_timeout_presence();
    mouse_delta_t mx;
    lcg_state = lcg_next(lcg_state);
    mx        = lcg_state[15:8];
    send_mouse(mx, lcg_state[23:16]);
    wait_cycles(MOUSE_TIMEOUT + 5);  // Phase back to X high
    stra_i = ~stra_i;
    wait_cycles(3);
    check_value(32'(joy_o[3:0]), 32'(reverse_nibble(mx[7:4])), "X high nibble");
    stra_i = ~stra_i;
    wait_cycles(3);
    check_value(32'(joy_o[3:0]), 32'(reverse_nibble(mx[3:0])), "X low nibble");
    wait_cycles(MOUSE_TIMEOUT + 5);
    stra_i = ~stra_i;
    wait_cycles(3);
    check_value(32'(joy_o[3:0]), 32'(reverse_nibble(mx[7:4])), "X high nibble after timeout");

    // Joystick activity drops the mouse
    joy_i = lcg_state[5:0] & 6'b111110;
    wait_cycles(2);
    check_value(32'(joy_o), 32'(JOY_IDLE), "Port released on presence loss");
    wait_cycles(WAIT_BOUND);
    check_value(32'(joy_o), 32'(joy_i), "Joystick after mouse removal");
    joy_i = JOY_IDLE;
    wait_cycles(1);
endtask

// ------------------------------
// Paddle helpers and tests
// ------------------------------
task automatic read_vaus_bits(output logic [8:0] bits);
    mouse_x_i      = '0;
    mouse_y_i      = '0;
    mouse_strobe_i = 1'b1;  // Held so pin 6 low does not clear presence
    stra_i         = 1'b1;
    wait_cycles(4);
    bits[8] = joy_o[3];
    check_value(32'(joy_o | 6'b001000), 32'(JOY_IDLE), "VAUS fixed lines");
    stra_i = 1'b0;
    for (int i = 7; i >= 0; i--) begin
        joy_i[JOY_PIN6] = 1'b0;
        wait_cycles(2);
        joy_i[JOY_PIN6] = 1'b1;
        wait_cycles(4);
        bits[i] = joy_o[3];
    end
    mouse_strobe_i = 1'b0;
    wait_cycles(1);
endtask

task automatic vaus_paddle();
    mouse_delta_t steps [7] = '{8'sd100, 8'sd100, 8'sd127, 8'sh80, 8'sh80, 8'sh80, 8'sd20};
    logic [8:0]   bits;
    int           pos;
    stra_i      = 1'b0;
    mouse_btn_i = 2'b11;
    send_mouse('0, '0);
    pad_mode_i = PAD_VAUS;
    wait_cycles(WAIT_BOUND);
    pos = int'(VAUS_CENTER);
    foreach (steps[i]) begin
        send_mouse(steps[i], '0);
        pos = pos - int'(steps[i]);  // Positive X moves toward VAUS_MIN
        if (pos < int'(VAUS_MIN))
            pos = int'(VAUS_MIN);
        if (pos > int'(VAUS_MAX))
            pos = int'(VAUS_MAX);
        read_vaus_bits(bits);
        check_value(32'(bits), 32'(pos), $sformatf("VAUS position after step %0d", i));
    end
endtask

task automatic check_msx_pulse(input int pos);
    int   waited;
    int   high;
    logic ok;
    stra_i = 1'b1;
    waited = 0;
    while (joy_o[3] == 1'b0 && waited < 10) begin
        wait_cycles(1);
        waited++;
    end
    check_value(32'(joy_o[3]), 32'd1, "MSX paddle pulse start");
    high = 0;
    while (joy_o[3] == 1'b1 && high < MAX_PULSE + 8) begin
        wait_cycles(1);
        high++;
    end
    ok = (high >= (pos + 1) * (SCALER_TICKS + 1)) && (high <= MAX_PULSE - (int'(MSXPAD_MAX) - pos)
         * (SCALER_TICKS + 1));
    check_value(32'(ok), 32'd1, $sformatf("MSX pulse of %0d cycles at position %0d", high, pos));
    stra_i = 1'b0;
    wait_cycles(3);
endtask

task automatic msx_paddle();
    mouse_delta_t steps [5] = '{8'sd127, 8'sd50, 8'sh80, 8'sh80, 8'sh80};
    int           pos;
    pad_mode_i = PAD_MSX;
    wait_cycles(WAIT_BOUND);  // Recentres both paddles
    pos = int'(MSXPAD_CENTER);
    check_msx_pulse(pos);
    foreach (steps[i]) begin
        send_mouse(steps[i], '0);
        pos = pos - int'(steps[i]);
        if (pos < 0)
            pos = 0;
        if (pos > int'(MSXPAD_MAX))
            pos = int'(MSXPAD_MAX);
        if (i == 1 || i == 4)
            check_msx_pulse(pos);  // Lower limit, then upper clamp
    end
endtask

// ==== dv/port_a_tb.sv ====
`timescale 1ns/100ps

module port_a_tb import port_a_pkg::*;;

    localparam int DISC_TICKS    = 4;
    localparam int PRESCALE_BITS = 2;
    localparam int MOUSE_TIMEOUT = 40;
    localparam int SCALER_TICKS  = 3;

    // ------------------------------
    // Run length budget
    // ------------------------------
    localparam int WAIT_BOUND  = (DISC_TICKS + 2) * (1 << PRESCALE_BITS) + 4;
    localparam int MAX_PULSE   = (int'(MSXPAD_MAX) + 2) * (SCALER_TICKS + 1) + 4;
    localparam int VAUS_READ   = 8 * 6 + 8;
    localparam int CYCLE_LIMIT = 10 + 6 * WAIT_BOUND + 3 * (MOUSE_TIMEOUT + 5)
                               + 7 * (VAUS_READ + 2) + 3 * (MAX_PULSE + 20) + 200;

    logic         clk_sys;
    logic         reset;
    joy_lines_t   joy_i;
    pad_mode_t    pad_mode_i;
    logic         stra_i;
    logic         mouse_strobe_i;
    mouse_delta_t mouse_x_i;
    mouse_delta_t mouse_y_i;
    logic [1:0]   mouse_btn_i;
    joy_lines_t   joy_o;

    logic [31:0]  lcg_state = 32'h99c4;
    int           errors    = 0;
    int           cycle_cnt = 0;

    port_a_top #(
        .DISC_TICKS    (DISC_TICKS),
        .PRESCALE_BITS (PRESCALE_BITS),
        .MOUSE_TIMEOUT (MOUSE_TIMEOUT),
        .SCALER_TICKS  (SCALER_TICKS)
    ) u_port_a_top (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .joy_i          (joy_i),
        .pad_mode_i     (pad_mode_i),
        .stra_i         (stra_i),
        .mouse_strobe_i (mouse_strobe_i),
        .mouse_x_i      (mouse_x_i),
        .mouse_y_i      (mouse_y_i),
        .mouse_btn_i    (mouse_btn_i),
        .joy_o          (joy_o)
    );

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;  // 4 ns period
    end

    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns: %s: got %0h, expected %0h", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // Inputs change 1 ns after the rising edge, outputs are read there too
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_sys);
        #1;
    endtask

    task automatic send_mouse(input mouse_delta_t x, input mouse_delta_t y);
        mouse_x_i      = x;
        mouse_y_i      = y;
        mouse_strobe_i = 1'b1;
        wait_cycles(1);
        mouse_strobe_i = 1'b0;
        wait_cycles(1);
    endtask

    `include "port_a_tests.svh"

    initial begin
        reset          = 1'b1;
        joy_i          = JOY_IDLE;
        pad_mode_i     = PAD_NONE;
        stra_i         = 1'b0;
        mouse_strobe_i = 1'b0;
        mouse_x_i      = '0;
        mouse_y_i      = '0;
        mouse_btn_i    = 2'b11;
        wait_cycles(10);
        reset = 1'b0;

        reset_and_passthrough();
        mouse_nibbles();
        mouse_timeout_presence();
        vaus_paddle();
        msx_paddle();

        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+dv
logic/port_a_pkg.sv
logic/port_a_connect.sv
logic/mouse_serializer.sv
logic/paddle_position.sv
logic/paddle_fsm.sv
logic/port_a_top.sv
dv/port_a_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the port A testbench, the result comes from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module port_a_tb -f files.f -o port_a_sim > sim.log 2>&1 \
    && ./obj_dir/port_a_sim >> sim.log 2>&1 \
    || echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
